//--- list.f
src/raster_pkg.sv
src/cmd_decoder.sv
src/pixel_executor.sv
src/framebuffer_streamer.sv
src/rasterix_backend.sv
verification/tb_rasterix_backend.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -f list.f --top-module tb_rasterix_backend -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1 \
    || echo "Build or simulation ended with an error"
cat sim.log 2>/dev/null
grep -q "Regression passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src/cmd_decoder.sv
/* Collects a header word and its payload words from the command stream and
   presents them to the executor as one operation */
`timescale 1ns/1ps

module cmd_decoder
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic                  s_cmd_axis_tvalid,
    output logic                  s_cmd_axis_tready,
    input  raster_pkg::cmd_word_t s_cmd_axis_tdata,

    output logic                  op_valid,
    input  logic                  op_ready,
    output raster_pkg::opcode_e   op_code,
    output raster_pkg::cmd_word_t op_header,
    output raster_pkg::cmd_word_t op_word0,
    output raster_pkg::cmd_word_t op_word1
);
    raster_pkg::dec_state_e state;
    raster_pkg::opcode_e    hdr_op;
    logic [1:0]             hdr_len;
    logic [1:0]             word_len;
    logic [1:0]             word_cnt;
    logic                   word_fire;

    // Payload word count per opcode, unknown codes carry none
    function automatic logic [1:0] payload_len(input raster_pkg::opcode_e op);
        case (op)
            raster_pkg::OP_SCISSOR:     payload_len = 2'd2;
            raster_pkg::OP_CLEAR_COLOR: payload_len = 2'd1;
            raster_pkg::OP_PIXEL:       payload_len = 2'd2;
            default:                    payload_len = 2'd0;
        endcase
    endfunction

    // Only one complete operation is buffered
    assign s_cmd_axis_tready = !op_valid;
    assign word_fire         = s_cmd_axis_tvalid && s_cmd_axis_tready;

    assign hdr_op = raster_pkg::opcode_e'(
        s_cmd_axis_tdata[raster_pkg::OPCODE_MSB:raster_pkg::OPCODE_LSB]);
    assign hdr_len = payload_len(hdr_op);
    assign op_code = raster_pkg::opcode_e'(
        op_header[raster_pkg::OPCODE_MSB:raster_pkg::OPCODE_LSB]);

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state    <= raster_pkg::DEC_HEADER;
            op_valid <= 1'b0;
            word_len <= 2'd0;
            word_cnt <= 2'd0;
        end
        else
        begin
            if (op_valid && op_ready)
                op_valid <= 1'b0;

            if (word_fire)
            begin
                if (state == raster_pkg::DEC_HEADER)
                begin
                    word_len <= hdr_len;
                    word_cnt <= 2'd0;
                    if (hdr_len == 2'd0)
                        op_valid <= 1'b1;
                    else
                        state <= raster_pkg::DEC_PAYLOAD;
                end
                else
                begin
                    word_cnt <= word_cnt + 2'd1;
                    if (word_cnt == word_len - 2'd1)
                    begin
                        op_valid <= 1'b1;
                        state    <= raster_pkg::DEC_HEADER;
                    end
                end
            end
        end
    end

    always_ff @(posedge aclk)
    begin
        if (word_fire)
        begin
            if (state == raster_pkg::DEC_HEADER)
                op_header <= s_cmd_axis_tdata;
            else if (word_cnt == 2'd0)
                op_word0 <= s_cmd_axis_tdata;
            else
                op_word1 <= s_cmd_axis_tdata;
        end
    end

endmodule

//--- src/framebuffer_streamer.sv
/* Streams the color buffer out row-major, one RGB565 pixel per beat, then runs
   the swap_fb / fb_swapped handshake with the display side */
`timescale 1ns/1ps

module framebuffer_streamer #(
    parameter int RES_BITS = 4
)
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic                  stream_start,
    output logic                  stream_done,

    output logic [2*RES_BITS-1:0] rd_addr,
    input  raster_pkg::pixel_t    rd_data,

    output logic                  m_framebuffer_axis_tvalid,
    input  logic                  m_framebuffer_axis_tready,
    output raster_pkg::pixel_t    m_framebuffer_axis_tdata,
    output logic                  m_framebuffer_axis_tlast,

    output logic                  swap_fb,
    input  logic                  fb_swapped
);
    localparam int ADDR_BITS = 2 * RES_BITS;
    localparam logic [ADDR_BITS-1:0] LAST_ADDR = '1;

    raster_pkg::stream_state_e state;
    logic [ADDR_BITS-1:0]      beat_addr;
    logic                      beat_fire;

    // rd_data always holds the pixel at beat_addr
    assign m_framebuffer_axis_tvalid = (state == raster_pkg::ST_SEND);
    assign m_framebuffer_axis_tdata  = rd_data;
    assign m_framebuffer_axis_tlast  = m_framebuffer_axis_tvalid && (beat_addr == LAST_ADDR);
    assign beat_fire                 = m_framebuffer_axis_tvalid && m_framebuffer_axis_tready;
    assign swap_fb                   = (state == raster_pkg::ST_SWAP);

    // Read one address ahead on a transfer to hide the read latency
    always_comb
    begin
        if (beat_fire)
            rd_addr = beat_addr + 1'b1;
        else
            rd_addr = beat_addr;
    end

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state       <= raster_pkg::ST_IDLE;
            beat_addr   <= '0;
            stream_done <= 1'b0;
        end
        else
        begin
            stream_done <= 1'b0;
            case (state)
                raster_pkg::ST_IDLE:
                begin
                    if (stream_start)
                        state <= raster_pkg::ST_SEND;
                end
                raster_pkg::ST_SEND:
                begin
                    if (beat_fire)
                    begin
                        // Wraps back to zero after the last beat
                        beat_addr <= beat_addr + 1'b1;
                        if (m_framebuffer_axis_tlast)
                            state <= raster_pkg::ST_SWAP;
                    end
                end
                raster_pkg::ST_SWAP:
                begin
                    if (fb_swapped)
                    begin
                        state       <= raster_pkg::ST_IDLE;
                        stream_done <= 1'b1;
                    end
                end
                default: state <= raster_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

//--- src/pixel_executor.sv
/* Holds the render state and the RGB565 color buffer. Executes clear, pixel
   write and swap operations from the decoder and serves buffer reads to the streamer */
`timescale 1ns/1ps

module pixel_executor #(
    parameter int RES_BITS = 4
)
(
    input  logic                      aclk,
    input  logic                      arst_n,

    input  logic                      op_valid,
    output logic                      op_ready,
    input  raster_pkg::opcode_e       op_code,
    input  raster_pkg::cmd_word_t     op_header,
    input  raster_pkg::cmd_word_t     op_word0,
    input  raster_pkg::cmd_word_t     op_word1,

    output logic                      stream_start,
    input  logic                      stream_done,

    input  logic [2*RES_BITS-1:0]     rd_addr,
    output raster_pkg::pixel_t        rd_data
);
    localparam int ADDR_BITS = 2 * RES_BITS;
    localparam int DEPTH     = 1 << ADDR_BITS;
    // x sits in the high byte of a coordinate word, y in the low byte
    localparam int X_POS     = 8;
    localparam int Y_POS     = 0;

    raster_pkg::exec_state_e state;
    raster_pkg::pixel_t      mem [DEPTH];
    logic                    scissor_en;
    logic [RES_BITS-1:0]     sc_x0;
    logic [RES_BITS-1:0]     sc_y0;
    logic [RES_BITS-1:0]     sc_x1;
    logic [RES_BITS-1:0]     sc_y1;
    raster_pkg::pixel_t      clear_color;
    raster_pkg::color_mask_t color_mask;
    logic [RES_BITS-1:0]     cx;
    logic [RES_BITS-1:0]     cy;
    logic                    pix_pending;
    logic [RES_BITS-1:0]     pix_x;
    logic [RES_BITS-1:0]     pix_y;
    raster_pkg::pixel_t      pix_color;
    logic                    op_fire;
    logic                    wr_req;
    logic [RES_BITS-1:0]     wr_x;
    logic [RES_BITS-1:0]     wr_y;
    raster_pkg::pixel_t      wr_color;
    logic                    in_scissor;
    logic                    wr_en;
    logic [ADDR_BITS-1:0]    wr_addr;

    assign op_ready = (state == raster_pkg::EX_IDLE);
    assign op_fire  = op_valid && op_ready;

    // A pending pixel write can never fall inside a clear sweep
    always_comb
    begin
        if (state == raster_pkg::EX_CLEAR)
        begin
            wr_req   = 1'b1;
            wr_x     = cx;
            wr_y     = cy;
            wr_color = clear_color;
        end
        else
        begin
            wr_req   = pix_pending;
            wr_x     = pix_x;
            wr_y     = pix_y;
            wr_color = pix_color;
        end
    end

    // Scissor bounds are inclusive on both ends
    assign in_scissor = !scissor_en ||
                        ((wr_x >= sc_x0) && (wr_x <= sc_x1) &&
                         (wr_y >= sc_y0) && (wr_y <= sc_y1));
    assign wr_en   = wr_req && in_scissor;
    assign wr_addr = {wr_y, wr_x};

    always_ff @(posedge aclk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state        <= raster_pkg::EX_IDLE;
            scissor_en   <= 1'b0;
            sc_x0        <= '0;
            sc_y0        <= '0;
            sc_x1        <= '0;
            sc_y1        <= '0;
            clear_color  <= '0;
            color_mask   <= raster_pkg::MASK_ALL;
            cx           <= '0;
            cy           <= '0;
            pix_pending  <= 1'b0;
            stream_start <= 1'b0;
        end
        else
        begin
            stream_start <= 1'b0;
            pix_pending  <= 1'b0;
            case (state)
                raster_pkg::EX_IDLE:
                begin
                    if (op_fire)
                    begin
                        case (op_code)
                            raster_pkg::OP_SCISSOR:
                            begin
                                scissor_en <= op_header[0];
                                sc_x0      <= op_word0[X_POS +: RES_BITS];
                                sc_y0      <= op_word0[Y_POS +: RES_BITS];
                                sc_x1      <= op_word1[X_POS +: RES_BITS];
                                sc_y1      <= op_word1[Y_POS +: RES_BITS];
                            end
                            raster_pkg::OP_CLEAR_COLOR: clear_color <= op_word0;
                            raster_pkg::OP_MASK:        color_mask  <= op_header[2:0];
                            raster_pkg::OP_CLEAR:
                            begin
                                state <= raster_pkg::EX_CLEAR;
                                cx    <= '0;
                                cy    <= '0;
                            end
                            raster_pkg::OP_PIXEL:       pix_pending <= 1'b1;
                            raster_pkg::OP_SWAP:
                            begin
                                state        <= raster_pkg::EX_SWAP;
                                stream_start <= 1'b1;
                            end
                            default:
                            begin
                            end
                        endcase
                    end
                end
                raster_pkg::EX_CLEAR:
                begin
                    // Row-major sweep, one pixel per cycle
                    cx <= cx + 1'b1;
                    if (&cx)
                    begin
                        cy <= cy + 1'b1;
                        if (&cy)
                            state <= raster_pkg::EX_IDLE;
                    end
                end
                raster_pkg::EX_SWAP:
                begin
                    if (stream_done)
                        state <= raster_pkg::EX_IDLE;
                end
                default: state <= raster_pkg::EX_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk)
    begin
        if (op_fire && (op_code == raster_pkg::OP_PIXEL))
        begin
            pix_x     <= op_word0[X_POS +: RES_BITS];
            pix_y     <= op_word0[Y_POS +: RES_BITS];
            pix_color <= op_word1;
        end
    end

    // Masked channels keep their stored value
    always_ff @(posedge aclk)
    begin
        if (wr_en)
        begin
            if (color_mask[raster_pkg::MASK_R])
                mem[wr_addr][raster_pkg::R_MSB:raster_pkg::R_LSB] <=
                    wr_color[raster_pkg::R_MSB:raster_pkg::R_LSB];
            if (color_mask[raster_pkg::MASK_G])
                mem[wr_addr][raster_pkg::G_MSB:raster_pkg::G_LSB] <=
                    wr_color[raster_pkg::G_MSB:raster_pkg::G_LSB];
            if (color_mask[raster_pkg::MASK_B])
                mem[wr_addr][raster_pkg::B_MSB:raster_pkg::B_LSB] <=
                    wr_color[raster_pkg::B_MSB:raster_pkg::B_LSB];
        end
        rd_data <= mem[rd_addr];
    end

endmodule

//--- src/raster_pkg.sv
/* Word widths, RGB565 layout, opcodes and FSM encodings shared by the raster back end.
   Referenced by scoped name from every stage */
package raster_pkg;

    localparam int CMD_WIDTH = 16;

    typedef logic [CMD_WIDTH-1:0] cmd_word_t;

    // RGB565, used both in the color buffer and on the output stream
    typedef logic [15:0] pixel_t;

    localparam int R_MSB = 15;
    localparam int R_LSB = 11;
    localparam int G_MSB = 10;
    localparam int G_LSB = 5;
    localparam int B_MSB = 4;
    localparam int B_LSB = 0;

    typedef logic [2:0] color_mask_t;

    localparam int MASK_R = 2;
    localparam int MASK_G = 1;
    localparam int MASK_B = 0;
    localparam color_mask_t MASK_ALL = 3'b111;

    localparam int OPCODE_MSB = 15;
    localparam int OPCODE_LSB = 12;

    typedef enum logic [3:0] {
        OP_NOP         = 4'd0,
        OP_SCISSOR     = 4'd1,
        OP_CLEAR_COLOR = 4'd2,
        OP_MASK        = 4'd3,
        OP_CLEAR       = 4'd4,
        OP_PIXEL       = 4'd5,
        OP_SWAP        = 4'd6
    } opcode_e;

    typedef enum logic {DEC_HEADER, DEC_PAYLOAD} dec_state_e;
    typedef enum logic [1:0] {EX_IDLE, EX_CLEAR, EX_SWAP} exec_state_e;
    typedef enum logic [1:0] {ST_IDLE, ST_SEND, ST_SWAP} stream_state_e;

endpackage

//--- src/rasterix_backend.sv
/* Top level of the raster back end. Commands go in on one stream, the
   framebuffer comes out on another after each swap */
`timescale 1ns/1ps

module rasterix_backend #(
    parameter int RES_BITS = 4
)
(
    input  logic                  aclk,
    input  logic                  arst_n,

    input  logic                  s_cmd_axis_tvalid,
    output logic                  s_cmd_axis_tready,
    input  raster_pkg::cmd_word_t s_cmd_axis_tdata,

    output logic                  m_framebuffer_axis_tvalid,
    input  logic                  m_framebuffer_axis_tready,
    output raster_pkg::pixel_t    m_framebuffer_axis_tdata,
    output logic                  m_framebuffer_axis_tlast,
    output logic                  swap_fb,
    input  logic                  fb_swapped
);
    logic                  op_valid;
    logic                  op_ready;
    raster_pkg::opcode_e   op_code;
    raster_pkg::cmd_word_t op_header;
    raster_pkg::cmd_word_t op_word0;
    raster_pkg::cmd_word_t op_word1;
    logic                  stream_start;
    logic                  stream_done;
    logic [2*RES_BITS-1:0] rd_addr;
    raster_pkg::pixel_t    rd_data;

    cmd_decoder i_decode (
        .aclk              (aclk),
        .arst_n            (arst_n),
        .s_cmd_axis_tvalid (s_cmd_axis_tvalid),
        .s_cmd_axis_tready (s_cmd_axis_tready),
        .s_cmd_axis_tdata  (s_cmd_axis_tdata),
        .op_valid          (op_valid),
        .op_ready          (op_ready),
        .op_code           (op_code),
        .op_header         (op_header),
        .op_word0          (op_word0),
        .op_word1          (op_word1)
    );

    pixel_executor #(
        .RES_BITS (RES_BITS)
    ) i_execute (
        .aclk         (aclk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .op_ready     (op_ready),
        .op_code      (op_code),
        .op_header    (op_header),
        .op_word0     (op_word0),
        .op_word1     (op_word1),
        .stream_start (stream_start),
        .stream_done  (stream_done),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    framebuffer_streamer #(
        .RES_BITS (RES_BITS)
    ) i_result (
        .aclk                      (aclk),
        .arst_n                    (arst_n),
        .stream_start              (stream_start),
        .stream_done               (stream_done),
        .rd_addr                   (rd_addr),
        .rd_data                   (rd_data),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .swap_fb                   (swap_fb),
        .fb_swapped                (fb_swapped)
    );

endmodule

//--- verification/tb_rasterix_backend.sv
/* Directed regression for the raster back end. Sends command words and compares
   every streamed frame with a pixel model of the color buffer */
`timescale 1ns/1ps

module tb_rasterix_backend;

    localparam int RES_BITS        = 4;
    localparam int NPIX            = 1 << (2 * RES_BITS);
    localparam int N_TESTS         = 6;
    localparam int WATCHDOG_CYCLES = N_TESTS * (4 * NPIX + 2 * NPIX + 500);
    localparam int STALL_CYCLES    = 1000;

    logic                    aclk;
    logic                    arst_n;
    logic                    s_cmd_axis_tvalid;
    logic                    s_cmd_axis_tready;
    raster_pkg::cmd_word_t   s_cmd_axis_tdata;
    logic                    m_framebuffer_axis_tvalid;
    logic                    m_framebuffer_axis_tready;
    raster_pkg::pixel_t      m_framebuffer_axis_tdata;
    logic                    m_framebuffer_axis_tlast;
    logic                    swap_fb;
    logic                    fb_swapped;

    // Reference model of the buffer and render state
    raster_pkg::pixel_t      model [NPIX];
    logic                    m_sc_en;
    logic [RES_BITS-1:0]     m_x0;
    logic [RES_BITS-1:0]     m_y0;
    logic [RES_BITS-1:0]     m_x1;
    logic [RES_BITS-1:0]     m_y1;
    raster_pkg::pixel_t      m_clear;
    raster_pkg::color_mask_t m_mask;
    logic [31:0]             lcg_state;
    int                      errors;
    int                      failed_tests;
    int                      start_errors;

    rasterix_backend #(
        .RES_BITS (RES_BITS)
    ) i_dut (
        .aclk                      (aclk),
        .arst_n                    (arst_n),
        .s_cmd_axis_tvalid         (s_cmd_axis_tvalid),
        .s_cmd_axis_tready         (s_cmd_axis_tready),
        .s_cmd_axis_tdata          (s_cmd_axis_tdata),
        .m_framebuffer_axis_tvalid (m_framebuffer_axis_tvalid),
        .m_framebuffer_axis_tready (m_framebuffer_axis_tready),
        .m_framebuffer_axis_tdata  (m_framebuffer_axis_tdata),
        .m_framebuffer_axis_tlast  (m_framebuffer_axis_tlast),
        .swap_fb                   (swap_fb),
        .fb_swapped                (fb_swapped)
    );

    initial
    begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_pixel(input string name, input raster_pkg::pixel_t exp,
                               input raster_pkg::pixel_t act);
        if (act !== exp)
        begin
            $display("ERROR %0t: %s expected %h got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("ERROR %0t: %s expected %b got %b", $time, name, exp, act);
            errors++;
        end
    endtask

    // Writes outside an enabled scissor are dropped
    // Masked channels keep the stored value
    function automatic void model_write(input logic [RES_BITS-1:0] x,
                                        input logic [RES_BITS-1:0] y,
                                        input raster_pkg::pixel_t c);
        logic [2*RES_BITS-1:0] idx;
        idx = {y, x};
        if (m_sc_en && (x < m_x0 || x > m_x1 || y < m_y0 || y > m_y1))
            return;
        if (m_mask[raster_pkg::MASK_R])
            model[idx][raster_pkg::R_MSB:raster_pkg::R_LSB] =
                c[raster_pkg::R_MSB:raster_pkg::R_LSB];
        if (m_mask[raster_pkg::MASK_G])
            model[idx][raster_pkg::G_MSB:raster_pkg::G_LSB] =
                c[raster_pkg::G_MSB:raster_pkg::G_LSB];
        if (m_mask[raster_pkg::MASK_B])
            model[idx][raster_pkg::B_MSB:raster_pkg::B_LSB] =
                c[raster_pkg::B_MSB:raster_pkg::B_LSB];
    endfunction

    function automatic raster_pkg::cmd_word_t make_header(input raster_pkg::opcode_e op,
                                                          input logic [11:0] arg);
        return {op, arg};
    endfunction

    function automatic raster_pkg::cmd_word_t coord_word(input logic [RES_BITS-1:0] x,
                                                         input logic [RES_BITS-1:0] y);
        return {8'(x), 8'(y)};
    endfunction

    // Starts and ends 1 ns after a rising edge
    task automatic send_word(input raster_pkg::cmd_word_t w);
        int wait_cycles;
        wait_cycles = 0;
        s_cmd_axis_tvalid = 1'b1;
        s_cmd_axis_tdata  = w;
        while (!s_cmd_axis_tready && wait_cycles < STALL_CYCLES)
        begin
            @(posedge aclk);
            #1;
            wait_cycles++;
        end
        if (!s_cmd_axis_tready)
        begin
            $display("Command stream stalled, word %h was never accepted", w);
            errors++;
        end
        @(posedge aclk);
        #1;
        s_cmd_axis_tvalid = 1'b0;
    endtask

    task automatic set_scissor(input logic en, input logic [RES_BITS-1:0] x0,
                               input logic [RES_BITS-1:0] y0, input logic [RES_BITS-1:0] x1,
                               input logic [RES_BITS-1:0] y1);
        send_word(make_header(raster_pkg::OP_SCISSOR, {11'd0, en}));
        send_word(coord_word(x0, y0));
        send_word(coord_word(x1, y1));
        m_sc_en = en;
        m_x0    = x0;
        m_y0    = y0;
        m_x1    = x1;
        m_y1    = y1;
    endtask

    task automatic load_clear_color(input raster_pkg::pixel_t c);
        send_word(make_header(raster_pkg::OP_CLEAR_COLOR, 12'd0));
        send_word(c);
        m_clear = c;
    endtask

    task automatic apply_mask(input raster_pkg::color_mask_t m);
        send_word(make_header(raster_pkg::OP_MASK, {9'd0, m}));
        m_mask = m;
    endtask

    task automatic clear_buffer();
        send_word(make_header(raster_pkg::OP_CLEAR, 12'd0));
        for (int i = 0; i < NPIX; i++)
            model_write(i[RES_BITS-1:0], i[2*RES_BITS-1:RES_BITS], m_clear);
    endtask

    task automatic write_pixel(input logic [RES_BITS-1:0] x, input logic [RES_BITS-1:0] y,
                               input raster_pkg::pixel_t c);
        send_word(make_header(raster_pkg::OP_PIXEL, 12'd0));
        send_word(coord_word(x, y));
        send_word(c);
        model_write(x, y, c);
    endtask

    task automatic write_random_pixels(input int count);
        logic [31:0] pos;
        logic [31:0] col;
        repeat (count)
        begin
            pos = lcg_next();
            col = lcg_next();
            write_pixel(pos[20 +: RES_BITS], pos[26 +: RES_BITS], col[31:16]);
        end
    endtask

    // Swap and compare every beat with the model before answering the swap handshake
    task automatic swap_and_compare(input logic random_ready);
        int          beats;
        int          cycles;
        logic [31:0] r;
        beats  = 0;
        cycles = 0;
        send_word(make_header(raster_pkg::OP_SWAP, 12'd0));
        while (beats < NPIX && cycles < 4 * NPIX + STALL_CYCLES)
        begin
            r = lcg_next();
            m_framebuffer_axis_tready = random_ready ? r[16] : 1'b1;
            if (m_framebuffer_axis_tvalid && m_framebuffer_axis_tready)
            begin
                check_pixel("m_framebuffer_axis_tdata", model[beats[2*RES_BITS-1:0]],
                            m_framebuffer_axis_tdata);
                check_flag("m_framebuffer_axis_tlast", beats == NPIX - 1,
                           m_framebuffer_axis_tlast);
                beats++;
            end
            @(posedge aclk);
            #1;
            cycles++;
        end
        m_framebuffer_axis_tready = 1'b0;
        if (beats < NPIX)
        begin
            $display("Framebuffer stream stalled after %0d of %0d beats", beats, NPIX);
            errors++;
        end
        check_flag("m_framebuffer_axis_tvalid", 1'b0, m_framebuffer_axis_tvalid);
        check_flag("swap_fb", 1'b1, swap_fb);
        repeat (4)
        begin
            @(posedge aclk);
            #1;
            check_flag("swap_fb", 1'b1, swap_fb);
        end
        fb_swapped = 1'b1;
        @(posedge aclk);
        #1;
        fb_swapped = 1'b0;
        check_flag("swap_fb", 1'b0, swap_fb);
    endtask

    task automatic reset_outputs();
        check_flag("m_framebuffer_axis_tvalid", 1'b0, m_framebuffer_axis_tvalid);
        check_flag("swap_fb", 1'b0, swap_fb);
        check_flag("s_cmd_axis_tready", 1'b1, s_cmd_axis_tready);
    endtask

    task automatic clear_and_swap();
        logic [31:0] r;
        r = lcg_next();
        load_clear_color(r[31:16]);
        clear_buffer();
        swap_and_compare(1'b0);
        // The second word only goes in once the executor has taken the first
        send_word(make_header(raster_pkg::OP_NOP, 12'd0));
        send_word(make_header(raster_pkg::OP_NOP, 12'd0));
    endtask

    task automatic pixel_frame();
        write_random_pixels(20);
        swap_and_compare(1'b0);
    endtask

    task automatic scissor_clear();
        logic [31:0] r;
        set_scissor(1'b1, 4'd3, 4'd5, 4'd9, 4'd12);
        r = lcg_next();
        load_clear_color(r[31:16] ^ m_clear);
        clear_buffer();
        swap_and_compare(1'b0);
        set_scissor(1'b0, 4'd3, 4'd5, 4'd9, 4'd12);
        r = lcg_next();
        write_pixel(4'd0, 4'd1, r[31:16]);
        swap_and_compare(1'b0);
    endtask

    task automatic green_only_mask();
        apply_mask(3'b010);
        write_random_pixels(10);
        swap_and_compare(1'b0);
        apply_mask(raster_pkg::MASK_ALL);
    endtask

    task automatic random_ready_frame();
        write_random_pixels(8);
        swap_and_compare(1'b1);
    endtask

    task automatic report_test(input string name, input int first_error);
        if (errors == first_error)
        begin
            $display("Test %s: ok", name);
        end
        else
        begin
            $display("Test %s: %0d errors", name, errors - first_error);
            failed_tests++;
        end
    endtask

    initial
    begin
        lcg_state                 = 32'h5579bd39;
        errors                    = 0;
        failed_tests              = 0;
        arst_n                    = 1'b0;
        s_cmd_axis_tvalid         = 1'b0;
        s_cmd_axis_tdata          = '0;
        m_framebuffer_axis_tready = 1'b0;
        fb_swapped                = 1'b0;
        m_sc_en                   = 1'b0;
        m_x0                      = '0;
        m_y0                      = '0;
        m_x1                      = '0;
        m_y1                      = '0;
        m_clear                   = '0;
        m_mask                    = raster_pkg::MASK_ALL;
        repeat (3) @(posedge aclk);
        #1;
        arst_n = 1'b1;
        @(posedge aclk);
        #1;
        start_errors = errors;
        reset_outputs();
        report_test("reset", start_errors);
        start_errors = errors;
        clear_and_swap();
        report_test("clear_swap", start_errors);
        start_errors = errors;
        pixel_frame();
        report_test("pixel_writes", start_errors);
        start_errors = errors;
        scissor_clear();
        report_test("scissor", start_errors);
        start_errors = errors;
        green_only_mask();
        report_test("mask", start_errors);
        start_errors = errors;
        random_ready_frame();
        report_test("backpressure", start_errors);
        $display("Tests run %0d, failed %0d, errors %0d", N_TESTS, failed_tests, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge aclk);
        $display("Watchdog expired, the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule
